// ==== build.f ====
+incdir+verilog
verilog/rv32i_types.sv
verilog/pipe_types.sv
verilog/control_rom.sv
verilog/alu.sv
verilog/cmp.sv
verilog/decode_stage.sv
verilog/instruction_execute.sv
verilog/ex_pipeline_top.sv
verif/ex_pipeline_tb.sv

// ==== Bender.yml ====
package:
  name: ex_pipeline

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/rv32i_types.sv
      - verilog/pipe_types.sv
      - verilog/control_rom.sv
      - verilog/alu.sv
      - verilog/cmp.sv
      - verilog/decode_stage.sv
      - verilog/instruction_execute.sv
      - verilog/ex_pipeline_top.sv
  - target: test
    files:
      - verif/ex_pipeline_tb.sv

// ==== verif/ex_pipeline_tb.sv ====
module ex_pipeline_tb import rv32i_types::*, pipe_types::*; ();

  localparam int N_MEM      = 32;     // Every width at every offset
  localparam int N_PER_CLS  = 24;
  localparam int N_CLASS    = 9 * N_PER_CLS;
  localparam int N_MIX      = 400;
  localparam int MAX_CYCLES = 4 + N_MEM + N_CLASS + N_MIX + 20;

  localparam logic [17:0] BR_F3 = {3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
  localparam logic [14:0] LD_F3 = {3'b000, 3'b001, 3'b010, 3'b100, 3'b101};

  typedef struct packed {
    logic [31:0] due;  // Cycle at which ex_mem holds this bundle
    ex_mem_t     b;
  } expect_t;

  logic      clk;
  logic      rst;
  rv32i_word pc;
  rv32i_word instruction;
  rv32i_word rs1_data;
  rv32i_word rs2_data;
  ex_mem_t   ex_mem;

  expect_t     exp_q[$];
  expect_t     cur;
  logic [31:0] cycle;
  logic [31:0] seed;

  ex_pipeline_top uut (
    .clk         (clk),
    .rst         (rst),
    .pc          (pc),
    .instruction (instruction),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .ex_mem      (ex_mem)
  );

  always #5 clk = ~clk;

  function automatic rv32i_word alu_model(logic [2:0] f3, logic alt, logic is_reg,
                                          rv32i_word a, rv32i_word b);
    rv32i_word r;
    case (f3)
      3'b000: r = (is_reg && alt) ? a - b : a + b;
      3'b001: r = a << b[4:0];
      3'b010: r = {31'b0, $signed(a) < $signed(b)};
      3'b011: r = {31'b0, a < b};
      3'b100: r = a ^ b;
      3'b101: begin
        if (alt) r = $signed(a) >>> b[4:0]; // srai and sra
        else     r = a >> b[4:0];
      end
      3'b110: r = a | b;
      default: r = a & b;
    endcase
    return r;
  endfunction

  function automatic logic branch_model(logic [2:0] f3, rv32i_word a, rv32i_word b);
    case (f3)
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return $signed(a) < $signed(b);
      3'b101:  return !($signed(a) < $signed(b));
      3'b110:  return a < b;
      default: return !(a < b);
    endcase
  endfunction

  // One nibble per offset with offset 3 on top
  function automatic logic [3:0] enable_model(logic [2:0] f3, logic [1:0] off);
    case (f3)
      3'b000, 3'b100: return 16'h8421 >> (off * 4); // Byte
      3'b001, 3'b101: return 16'h8C63 >> (off * 4); // Half
      3'b010:         return 16'h8CEF >> (off * 4); // Word
      default:        return 4'b1111;
    endcase
  endfunction

  function automatic ex_mem_t ref_model(rv32i_word p, rv32i_word w, rv32i_word r1,
                                        rv32i_word r2);
    ex_mem_t   r;
    rv32i_word imm_i;
    rv32i_word imm_s;
    rv32i_word imm_b;
    rv32i_word imm_u;
    rv32i_word imm_j;
    imm_i = {{20{w[31]}}, w[31:20]};
    imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
    imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    imm_u = {w[31:12], 12'b0};
    imm_j = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
    r = '0;
    r.pc = p;
    r.instruction = w;
    r.rs2_out = r2;
    r.ctrl.opcode = rv32i_opcode'(w[6:0]);
    r.ctrl.funct3 = w[14:12];
    case (w[6:0])
      7'b0110111: begin
        r.alu_out = imm_u;
        r.ctrl.alumux2_sel = alumux2_u_imm;
      end
      7'b0010111: begin
        r.alu_out = p + imm_u;
        r.ctrl.alumux1_sel = alumux1_pc;
        r.ctrl.alumux2_sel = alumux2_u_imm;
      end
      7'b1101111: begin
        r.alu_out = p + 32'd4; // Link address
        r.br_en = 1'b1;
        r.ctrl.alumux1_sel = alumux1_pc; // Operands of the jump target
        r.ctrl.alumux2_sel = alumux2_j_imm;
      end
      7'b1100111: begin
        r.alu_out = p + 32'd4;
        r.br_en = 1'b1;
        r.ctrl.alumux2_sel = alumux2_i_imm;
      end
      7'b1100011: begin
        r.alu_out = p + imm_b;
        r.br_en = branch_model(w[14:12], r1, r2);
        r.ctrl.cmpop = branch_funct3_t'(w[14:12]);
        r.ctrl.alumux1_sel = alumux1_pc;
        r.ctrl.alumux2_sel = alumux2_b_imm;
      end
      7'b0000011: begin
        r.alu_out = r1 + imm_i;
        r.ctrl.mem_read = 1'b1;
        r.ctrl.alumux2_sel = alumux2_i_imm;
      end
      7'b0100011: begin
        r.alu_out = r1 + imm_s;
        r.ctrl.mem_write = 1'b1;
        r.ctrl.alumux2_sel = alumux2_s_imm;
      end
      7'b0010011: begin
        r.alu_out = alu_model(w[14:12], w[30], 1'b0, r1, imm_i);
        r.ctrl.alumux2_sel = alumux2_i_imm;
        r.ctrl.cmpmux_sel = cmpmux_i_imm;
      end
      default: begin
        r.alu_out = alu_model(w[14:12], w[30], 1'b1, r1, r2);
        r.ctrl.alumux2_sel = alumux2_rs2;
      end
    endcase
    if (w[6:0] inside {7'b0010011, 7'b0110011}) begin
      case (w[14:12])
        3'b000:  r.ctrl.aluop = (w[5] && w[30]) ? alu_sub : alu_add; // w[5] marks R-type
        3'b001:  r.ctrl.aluop = alu_sll;
        3'b010:  r.ctrl.cmpop = blt; // Set-less-than uses the comparator
        3'b011:  r.ctrl.cmpop = bltu;
        3'b100:  r.ctrl.aluop = alu_xor;
        3'b101:  r.ctrl.aluop = w[30] ? alu_sra : alu_srl;
        3'b110:  r.ctrl.aluop = alu_or;
        default: r.ctrl.aluop = alu_and;
      endcase
    end
    r.ctrl.load_regfile = !(w[6:0] inside {7'b1100011, 7'b0100011});
    if (r.ctrl.mem_read || r.ctrl.mem_write) begin
      r.mem_byte_enable = enable_model(w[14:12], r.alu_out[1:0]);
    end
    return r;
  endfunction

  // Random fields within one instruction class
  function automatic rv32i_word gen_instr(int cls);
    rv32i_word w;
    w = $urandom;
    case (cls)
      0: w[6:0] = 7'b0110111;
      1: w[6:0] = 7'b0010111;
      2: w[6:0] = 7'b1101111;
      3: begin
        w[6:0] = 7'b1100111;
        w[14:12] = 3'b000;
      end
      4: begin
        w[6:0] = 7'b1100011;
        w[14:12] = BR_F3[$urandom_range(0, 5) * 3 +: 3];
      end
      5: begin
        w[6:0] = 7'b0000011;
        w[14:12] = LD_F3[$urandom_range(0, 4) * 3 +: 3];
      end
      6: begin
        w[6:0] = 7'b0100011;
        w[14:12] = 3'($urandom_range(0, 2));
      end
      7: w[6:0] = 7'b0010011;
      default: w[6:0] = 7'b0110011;
    endcase
    return w;
  endfunction

  function automatic rv32i_word rand_rs2(rv32i_word r1);
    if ($urandom_range(0, 3) == 0) return r1; // Equal operands for beq and bge
    return $urandom;
  endfunction

  task automatic check(string name, logic [255:0] got, logic [255:0] exp);
    if (got !== exp) begin
      $display("FAILED at time %0t: %s got %0h expected %0h", $time, name, got, exp);
      $display("Result: FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic send(rv32i_word w, rv32i_word r1, rv32i_word r2);
    expect_t   e;
    rv32i_word p;
    p = $urandom;
    p[1:0] = 2'b00;
    pc = p;
    instruction = w;
    rs1_data = r1;
    rs2_data = r2;
    e.due = cycle + 2;
    e.b = ref_model(p, w, r1, r2);
    exp_q.push_back(e);
    @(negedge clk);
  endtask

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles with %0d bundles still expected", cycle, exp_q.size());
      $display("Result: FAILED");
      $fatal(1, "timeout");
    end
  end

  // Outputs are sampled on the falling edge half a cycle after they change
  always @(negedge clk) begin
    if (exp_q.size() != 0 && exp_q[0].due == cycle) begin
      cur = exp_q.pop_front();
      check("ctrl", ex_mem.ctrl, cur.b.ctrl);
      check("pc", ex_mem.pc, cur.b.pc);
      check("instruction", ex_mem.instruction, cur.b.instruction);
      check("alu_out", ex_mem.alu_out, cur.b.alu_out);
      check("rs2_out", ex_mem.rs2_out, cur.b.rs2_out);
      check("br_en", ex_mem.br_en, cur.b.br_en);
      check("mem_byte_enable", ex_mem.mem_byte_enable, cur.b.mem_byte_enable);
    end
  end

  initial begin
    rv32i_word  w;
    rv32i_word  r1;
    logic [1:0] lo;
    expect_t    z;
    seed = 32'h3b26_ab8e;
    void'($urandom(seed));
    clk = 1'b0;
    rst = 1'b1;
    cycle = '0;
    pc = '0;
    instruction = 32'h0000_0013; // addi x0, x0, 0
    rs1_data = '0;
    rs2_data = '0;
    // Three reset cycles plus the no-op that follows release
    for (int i = 1; i <= 4; i++) begin
      z = '0;
      z.due = i;
      exp_q.push_back(z);
    end
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    for (int k = 0; k < 8; k++) begin
      for (int off = 0; off < 4; off++) begin
        if (k < 5) begin
          w = gen_instr(5);
          w[14:12] = LD_F3[(4 - k) * 3 +: 3];
          lo = w[21:20];
        end else begin
          w = gen_instr(6);
          w[14:12] = 3'(k - 5);
          lo = w[8:7];
        end
        r1 = $urandom;
        r1[1:0] = 2'(off) - lo; // Land the address on this offset
        send(w, r1, $urandom);
      end
    end
    for (int cls = 0; cls < 9; cls++) begin
      for (int i = 0; i < N_PER_CLS; i++) begin
        w = gen_instr(cls);
        if (cls >= 7) w[30] = i[0]; // Alternate add/sub and srl/sra
        r1 = $urandom;
        send(w, r1, rand_rs2(r1));
      end
    end
    for (int i = 0; i < N_MIX; i++) begin
      w = gen_instr($urandom_range(0, 8));
      r1 = $urandom;
      send(w, r1, rand_rs2(r1));
    end
    while (exp_q.size() != 0) @(negedge clk);
    @(negedge clk);
    $display("Result: PASSED");
    $finish;
  end

endmodule

// ==== verilog/ex_pipeline_top.sv ====
module ex_pipeline_top import rv32i_types::*, pipe_types::*; (
  input  logic      clk,
  input  logic      rst,
  input  rv32i_word pc,
  input  rv32i_word instruction,
  input  rv32i_word rs1_data,
  input  rv32i_word rs2_data,
  output ex_mem_t   ex_mem
);

  id_ex_t id_ex; // Decode to execute bundle

  decode_stage decode_stage (
    .clk         (clk),
    .rst         (rst),
    .pc          (pc),
    .instruction (instruction),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .id_ex       (id_ex)
  );

  instruction_execute instruction_execute (
    .clk    (clk),
    .rst    (rst),
    .id_ex  (id_ex),
    .ex_mem (ex_mem)
  );

endmodule

// ==== verilog/instruction_execute.sv ====
module instruction_execute import rv32i_types::*, pipe_types::*; (
  input  logic    clk,
  input  logic    rst,
  input  id_ex_t  id_ex,
  output ex_mem_t ex_mem
);

  rv32i_word  alu_f;
  rv32i_word  alu_result;
  logic       cmp_out;
  logic       br_en;
  logic       is_slt;
  logic       mem_access;
  logic [1:0] offset;
  logic [3:0] mem_byte_enable;

  alu alu (
    .aluop (id_ex.ctrl.aluop),
    .a     (id_ex.alu_in_1),
    .b     (id_ex.alu_in_2),
    .f     (alu_f)
  );

  cmp cmp (
    .cmpop   (id_ex.ctrl.cmpop),
    .rs1_out (id_ex.rs1_out),
    .cmp_in  (id_ex.cmp_in),
    .br_en   (cmp_out)
  );

  assign is_slt = (id_ex.ctrl.opcode inside {op_imm, op_reg}) &&
                  (id_ex.ctrl.funct3 inside {3'b010, 3'b011});
  assign mem_access = id_ex.ctrl.mem_read || id_ex.ctrl.mem_write;

  always_comb begin
    case (id_ex.ctrl.opcode)
      op_lui:          alu_result = id_ex.alu_in_2; // u_imm straight through
      op_jal, op_jalr: alu_result = id_ex.pc + 32'd4; // Link address, target is resolved later
      op_imm, op_reg:  alu_result = is_slt ? rv32i_word'(cmp_out) : alu_f;
      default:         alu_result = alu_f;
    endcase
    case (id_ex.ctrl.opcode)
      op_br:           br_en = cmp_out;
      op_jal, op_jalr: br_en = 1'b1;
      default:         br_en = 1'b0;
    endcase
  end

  assign offset = alu_result[1:0];

  // Loads and stores share width codes; enables clip at the word boundary
  always_comb begin
    case (load_funct3_t'(id_ex.ctrl.funct3))
      lb, lbu: mem_byte_enable = 4'b0001 << offset;
      lh, lhu: mem_byte_enable = 4'b0011 << offset;
      lw:      mem_byte_enable = 4'b1111 << offset;
      default: mem_byte_enable = 4'b1111;
    endcase
    if (!mem_access) begin
      mem_byte_enable = 4'b0000; // Only memory ops drive byte enables
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ex_mem <= '0;
    end else begin
      ex_mem.ctrl            <= id_ex.ctrl;
      ex_mem.pc              <= id_ex.pc;
      ex_mem.instruction     <= id_ex.instruction;
      ex_mem.alu_out         <= alu_result;
      ex_mem.rs2_out         <= id_ex.rs2;
      ex_mem.br_en           <= br_en;
      ex_mem.mem_byte_enable <= mem_byte_enable;
    end
  end

  // A memory op leaving execute must touch at least one byte
  byte_enable_set: assert property (@(posedge clk) disable iff (rst)
    (ex_mem.ctrl.mem_read || ex_mem.ctrl.mem_write) |-> (ex_mem.mem_byte_enable != 4'b0000))
    else $error("execute: memory op with empty byte enable");

endmodule

// ==== verilog/decode_stage.sv ====
`include "rv32i_consts.svh"

module decode_stage import rv32i_types::*, pipe_types::*; (
  input  logic      clk,
  input  logic      rst,
  input  rv32i_word pc,
  input  rv32i_word instruction,
  input  rv32i_word rs1_data,
  input  rv32i_word rs2_data,
  output id_ex_t    id_ex
);

  rv32i_opcode       opcode;
  rv32i_control_word ctrl;
  rv32i_word         i_imm;
  rv32i_word         s_imm;
  rv32i_word         b_imm;
  rv32i_word         u_imm;
  rv32i_word         j_imm;
  rv32i_word         alu_in_1;
  rv32i_word         alu_in_2;
  rv32i_word         cmp_in;

  assign opcode = rv32i_opcode'(instruction[`OPCODE_LSB +: `OPCODE_W]);

  control_rom control_rom (
    .opcode (opcode),
    .funct3 (instruction[`FUNCT3_LSB +: `FUNCT3_W]),
    .funct7 (instruction[`FUNCT7_LSB +: `FUNCT7_W]),
    .ctrl   (ctrl)
  );

  // Sign extension always from bit 31
  assign i_imm = {{21{instruction[31]}}, instruction[30:20]};
  assign s_imm = {{21{instruction[31]}}, instruction[30:25], instruction[11:7]};
  assign b_imm = {{20{instruction[31]}}, instruction[7], instruction[30:25],
                  instruction[11:8], 1'b0};
  assign u_imm = {instruction[31:12], 12'h000};
  assign j_imm = {{12{instruction[31]}}, instruction[19:12], instruction[20],
                  instruction[30:21], 1'b0};

  always_comb begin
    alu_in_1 = (ctrl.alumux1_sel == alumux1_pc) ? pc : rs1_data;
    case (ctrl.alumux2_sel)
      alumux2_i_imm: alu_in_2 = i_imm;
      alumux2_u_imm: alu_in_2 = u_imm;
      alumux2_b_imm: alu_in_2 = b_imm;
      alumux2_s_imm: alu_in_2 = s_imm;
      alumux2_j_imm: alu_in_2 = j_imm;
      default:       alu_in_2 = rs2_data;
    endcase
    cmp_in = (ctrl.cmpmux_sel == cmpmux_i_imm) ? i_imm : rs2_data; // i_imm for slti/sltiu
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      id_ex <= '0;
    end else begin
      id_ex.ctrl        <= ctrl;
      id_ex.pc          <= pc;
      id_ex.instruction <= instruction;
      id_ex.alu_in_1    <= alu_in_1;
      id_ex.alu_in_2    <= alu_in_2;
      id_ex.cmp_in      <= cmp_in;
      id_ex.rs1_out     <= rs1_data;
      id_ex.rs2         <= rs2_data;
    end
  end

  // Every opcode reaching the ROM out of reset should be one it knows
  opcode_known: assert property (@(posedge clk) disable iff (rst)
    opcode inside {op_lui, op_auipc, op_jal, op_jalr, op_br,
                   op_load, op_store, op_imm, op_reg})
    else $error("decode: opcode %b outside rv32i_opcode", opcode);

endmodule

// ==== verilog/cmp.sv ====
module cmp import rv32i_types::*; (
  input  branch_funct3_t cmpop,
  input  rv32i_word      rs1_out,
  input  rv32i_word      cmp_in,
  output logic           br_en
);

  logic eq;
  logic lt;
  logic ltu;

  assign eq  = (rs1_out == cmp_in);
  assign lt  = ($signed(rs1_out) < $signed(cmp_in));
  assign ltu = (rs1_out < cmp_in);

  always_comb begin
    case (cmpop)
      beq:     br_en = eq;
      bne:     br_en = !eq;
      blt:     br_en = lt;  // Also the slt result
      bge:     br_en = !lt;
      bltu:    br_en = ltu; // Also the sltu result
      bgeu:    br_en = !ltu;
      default: br_en = 1'b0;
    endcase
  end

endmodule

// ==== verilog/alu.sv ====
module alu import rv32i_types::*; (
  input  alu_ops    aluop,
  input  rv32i_word a,
  input  rv32i_word b,
  output rv32i_word f
);

  logic [4:0] shamt;

  assign shamt = b[4:0];

  always_comb begin
    case (aluop)
      alu_add: f = a + b;
      alu_sll: f = a << shamt;
      alu_sra: f = rv32i_word'($signed(a) >>> shamt); // Sign fills from the top
      alu_sub: f = a - b;
      alu_xor: f = a ^ b;
      alu_srl: f = a >> shamt;
      alu_or:  f = a | b;
      alu_and: f = a & b;
      default: f = a + b;
    endcase
  end

endmodule

// ==== verilog/control_rom.sv ====
`include "rv32i_consts.svh"

module control_rom import rv32i_types::*; (
  input  rv32i_opcode          opcode,
  input  logic [`FUNCT3_W-1:0] funct3,
  input  logic [`FUNCT7_W-1:0] funct7,
  output rv32i_control_word    ctrl
);

  logic alt;
  logic is_imm;

  assign alt    = funct7[5]; // Selects sub or sra
  assign is_imm = (opcode == op_imm);

  always_comb begin
    ctrl        = '0;
    ctrl.opcode = opcode;
    ctrl.funct3 = funct3;
    ctrl.aluop  = alu_add; // Address and pc arithmetic
    case (opcode)
      op_lui: begin
        ctrl.alumux2_sel  = alumux2_u_imm;
        ctrl.load_regfile = 1'b1;
      end
      op_auipc: begin
        ctrl.alumux1_sel  = alumux1_pc;
        ctrl.alumux2_sel  = alumux2_u_imm;
        ctrl.load_regfile = 1'b1;
      end
      op_jal: begin
        ctrl.alumux1_sel  = alumux1_pc;
        ctrl.alumux2_sel  = alumux2_j_imm;
        ctrl.load_regfile = 1'b1;
      end
      op_jalr: begin
        ctrl.alumux2_sel  = alumux2_i_imm;
        ctrl.load_regfile = 1'b1;
      end
      op_br: begin
        ctrl.alumux1_sel = alumux1_pc;
        ctrl.alumux2_sel = alumux2_b_imm;
        ctrl.cmpop       = branch_funct3_t'(funct3);
      end
      op_load: begin
        ctrl.alumux2_sel  = alumux2_i_imm;
        ctrl.mem_read     = 1'b1;
        ctrl.load_regfile = 1'b1;
      end
      op_store: begin
        ctrl.alumux2_sel = alumux2_s_imm;
        ctrl.mem_write   = 1'b1;
      end
      op_imm, op_reg: begin
        ctrl.load_regfile = 1'b1;
        ctrl.alumux2_sel  = is_imm ? alumux2_i_imm : alumux2_rs2;
        ctrl.cmpmux_sel   = is_imm ? cmpmux_i_imm : cmpmux_rs2;
        case (funct3)
          3'b000:  ctrl.aluop = (!is_imm && alt) ? alu_sub : alu_add;
          3'b001:  ctrl.aluop = alu_sll;
          3'b010:  ctrl.cmpop = blt;  // slt goes through the comparator
          3'b011:  ctrl.cmpop = bltu; // sltu
          3'b100:  ctrl.aluop = alu_xor;
          3'b101:  ctrl.aluop = alt ? alu_sra : alu_srl;
          3'b110:  ctrl.aluop = alu_or;
          default: ctrl.aluop = alu_and;
        endcase
      end
      default: ctrl = '0; // Unsupported opcode becomes a no-op
    endcase
  end

endmodule

// ==== verilog/pipe_types.sv ====
package pipe_types;

  import rv32i_types::*;

  // Decode to execute
  typedef struct packed {
    rv32i_control_word ctrl;
    rv32i_word         pc;
    rv32i_word         instruction;
    rv32i_word         alu_in_1;
    rv32i_word         alu_in_2;
    rv32i_word         cmp_in;
    rv32i_word         rs1_out;
    rv32i_word         rs2;
  } id_ex_t;

  // Execute to memory
  typedef struct packed {
    rv32i_control_word ctrl;
    rv32i_word         pc;
    rv32i_word         instruction;
    rv32i_word         alu_out;
    rv32i_word         rs2_out;
    logic              br_en;
    logic [3:0]        mem_byte_enable;
  } ex_mem_t;

endpackage

// ==== verilog/rv32i_types.sv ====
`include "rv32i_consts.svh"

package rv32i_types;

  typedef logic [`XLEN-1:0] rv32i_word;

  typedef enum logic [`OPCODE_W-1:0] {
    op_lui   = 7'b0110111,
    op_auipc = 7'b0010111,
    op_jal   = 7'b1101111,
    op_jalr  = 7'b1100111,
    op_br    = 7'b1100011,
    op_load  = 7'b0000011,
    op_store = 7'b0100011,
    op_imm   = 7'b0010011,
    op_reg   = 7'b0110011
  } rv32i_opcode;

  // Not funct3 aligned, control_rom does the mapping
  typedef enum logic [2:0] {
    alu_add = 3'b000,
    alu_sll = 3'b001,
    alu_sra = 3'b010,
    alu_sub = 3'b011,
    alu_xor = 3'b100,
    alu_srl = 3'b101,
    alu_or  = 3'b110,
    alu_and = 3'b111
  } alu_ops;

  typedef enum logic [`FUNCT3_W-1:0] {
    beq  = 3'b000,
    bne  = 3'b001,
    blt  = 3'b100,
    bge  = 3'b101,
    bltu = 3'b110,
    bgeu = 3'b111
  } branch_funct3_t;

  // Stores use the same width codes (sb, sh, sw)
  typedef enum logic [`FUNCT3_W-1:0] {
    lb  = 3'b000,
    lh  = 3'b001,
    lw  = 3'b010,
    lbu = 3'b100,
    lhu = 3'b101
  } load_funct3_t;

  typedef enum logic {
    alumux1_rs1 = 1'b0,
    alumux1_pc  = 1'b1
  } alumux1_sel_t;

  typedef enum logic [2:0] {
    alumux2_i_imm = 3'd0,
    alumux2_u_imm = 3'd1,
    alumux2_b_imm = 3'd2,
    alumux2_s_imm = 3'd3,
    alumux2_j_imm = 3'd4,
    alumux2_rs2   = 3'd5
  } alumux2_sel_t;

  typedef enum logic {
    cmpmux_rs2   = 1'b0,
    cmpmux_i_imm = 1'b1
  } cmpmux_sel_t;

  // All zero means no-op
  typedef struct packed {
    rv32i_opcode           opcode;
    alu_ops                aluop;
    branch_funct3_t        cmpop;
    alumux1_sel_t          alumux1_sel;
    alumux2_sel_t          alumux2_sel;
    cmpmux_sel_t           cmpmux_sel;
    logic                  load_regfile;
    logic                  mem_read;
    logic                  mem_write;
    logic [`FUNCT3_W-1:0]  funct3;
  } rv32i_control_word;

endpackage

// ==== verilog/rv32i_consts.svh ====
`ifndef RV32I_CONSTS_SVH
`define RV32I_CONSTS_SVH

// Datapath width
`define XLEN 32

// Instruction field widths
`define OPCODE_W 7
`define FUNCT3_W 3
`define FUNCT7_W 7

// Instruction field positions
`define OPCODE_LSB 0
`define FUNCT3_LSB 12
`define FUNCT7_LSB 25

`endif
